// ==== ex_cfg_pkg.sv ====
// Datapath width and register-file address constants, register address type

package ex_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Default word width of the execute stage
  parameter int XLEN_DEF = 32;

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  // Address width covers the integer and extended register banks
  parameter int REG_ADDR_W = 6;

  // Register address as carried on both write ports
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

// ==== ex_op_pkg.sv ====
// ALU operation and multiplier operation encodings

package ex_op_pkg;

  // ALU operations
  // Arithmetic, logic and shifts come first, then the compare group
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operations
  // Low word is single cycle, the three high-word forms take two
  typedef enum logic [1:0] {
    MUL_L   = 2'd0,
    MUL_H   = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HU  = 2'd3
  } mul_op_e;

endpackage

// ==== ex_alu.sv ====
// Integer ALU: adder/subtractor, logic ops, barrel shifter, shared comparator
`timescale 1ns/1ps

module ex_alu #(
  parameter int XLEN = 32
) (
  input  logic                enable_i,
  input  ex_op_pkg::alu_op_e  operator_i,
  input  logic [XLEN-1:0]     operand_a_i,
  input  logic [XLEN-1:0]     operand_b_i,
  output logic [XLEN-1:0]     result_o,
  output logic                cmp_result_o
);

  // Shift amount width follows the word width
  localparam int SHAMT_W = $clog2(XLEN);

  logic                   is_sub;
  logic [XLEN-1:0]        adder_b;
  logic [XLEN-1:0]        adder_result;
  logic [SHAMT_W-1:0]     shamt;
  logic [XLEN-1:0]        shift_result;
  logic                   cmp_signed;
  logic signed [XLEN:0]   cmp_a;
  logic signed [XLEN:0]   cmp_b;
  logic                   is_equal;
  logic                   is_less;
  logic                   cmp_raw;

  ////////////////////////////////////////////////////////////
  // Adder / subtractor
  ////////////////////////////////////////////////////////////

  // Two's complement subtract through inverted B and carry in
  assign is_sub       = (operator_i == ex_op_pkg::ALU_SUB);
  assign adder_b      = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + {{(XLEN-1){1'b0}}, is_sub};

  ////////////////////////////////////////////////////////////
  // Barrel shifter
  ////////////////////////////////////////////////////////////

  // Only the low bits of B count as shift amount
  assign shamt = operand_b_i[SHAMT_W-1:0];

  always_comb begin
    case (operator_i)
      ex_op_pkg::ALU_SLL: shift_result = operand_a_i << shamt;
      ex_op_pkg::ALU_SRA: shift_result = $unsigned($signed(operand_a_i) >>> shamt);
      default:            shift_result = operand_a_i >> shamt;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////

  // Signed forms extend with the MSB, unsigned forms with zero
  assign cmp_signed = (operator_i == ex_op_pkg::ALU_SLT) ||
                      (operator_i == ex_op_pkg::ALU_LT)  ||
                      (operator_i == ex_op_pkg::ALU_GE);

  assign cmp_a    = $signed({cmp_signed & operand_a_i[XLEN-1], operand_a_i});
  assign cmp_b    = $signed({cmp_signed & operand_b_i[XLEN-1], operand_b_i});
  assign is_equal = (operand_a_i == operand_b_i);
  assign is_less  = (cmp_a < cmp_b);

  // One compare result shared by set-less-than and branches
  always_comb begin
    case (operator_i)
      ex_op_pkg::ALU_EQ:   cmp_raw = is_equal;
      ex_op_pkg::ALU_NE:   cmp_raw = ~is_equal;
      ex_op_pkg::ALU_SLT,
      ex_op_pkg::ALU_SLTU,
      ex_op_pkg::ALU_LT,
      ex_op_pkg::ALU_LTU:  cmp_raw = is_less;
      ex_op_pkg::ALU_GE,
      ex_op_pkg::ALU_GEU:  cmp_raw = ~is_less;
      default:             cmp_raw = 1'b0;
    endcase
  end

  // No branch decision unless the ALU is in use
  assign cmp_result_o = enable_i & cmp_raw;

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ex_op_pkg::ALU_ADD,
      ex_op_pkg::ALU_SUB: result_o = adder_result;
      ex_op_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_op_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_op_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_op_pkg::ALU_SLL,
      ex_op_pkg::ALU_SRL,
      ex_op_pkg::ALU_SRA: result_o = shift_result;
      // Compare group returns the flag zero extended
      default:            result_o = {{(XLEN-1){1'b0}}, cmp_raw};
    endcase
  end

endmodule

// ==== ex_mult.sv ====
// Integer multiplier with single-cycle low word and two-cycle high-word sequencer
`timescale 1ns/1ps

module ex_mult #(
  parameter int XLEN = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  ex_op_pkg::mul_op_e  operator_i,
  input  logic [XLEN-1:0]     op_a_i,
  input  logic [XLEN-1:0]     op_b_i,
  input  logic                ex_ready_i,
  output logic [XLEN-1:0]     result_o,
  output logic                ready_o,
  output logic                multicycle_o
);

  // Extended operands are one bit wider, so the product is 2*XLEN+2
  localparam int PROD_W = 2 * XLEN + 2;

  typedef enum logic {
    MS_IDLE,
    MS_HIGH
  } mult_state_e;

  mult_state_e              state_q;
  mult_state_e              state_d;
  logic                     sign_a;
  logic                     sign_b;
  logic signed [XLEN:0]     op_a_ext;
  logic signed [XLEN:0]     op_b_ext;
  logic signed [PROD_W-1:0] product;
  logic                     is_high_op;
  logic                     start_high;
  logic [XLEN-1:0]          mulh_q;

  ////////////////////////////////////////////////////////////
  // Operand extension and product
  ////////////////////////////////////////////////////////////

  // MULH both signed, MULHSU only A signed, MULHU and MUL unsigned
  always_comb begin
    sign_a = 1'b0;
    sign_b = 1'b0;
    case (operator_i)
      ex_op_pkg::MUL_H: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      ex_op_pkg::MUL_HSU: begin
        sign_a = 1'b1;
      end
      default: begin
        sign_a = 1'b0;
        sign_b = 1'b0;
      end
    endcase
  end

  assign op_a_ext = $signed({sign_a & op_a_i[XLEN-1], op_a_i});
  assign op_b_ext = $signed({sign_b & op_b_i[XLEN-1], op_b_i});

  // Full signed product, low word is the same for every sign mode
  assign product = op_a_ext * op_b_ext;

  ////////////////////////////////////////////////////////////
  // High-word sequencer
  ////////////////////////////////////////////////////////////

  assign is_high_op = (operator_i != ex_op_pkg::MUL_L);

  // New high-word request only from idle, the held inputs must not retrigger
  assign start_high = (state_q == MS_IDLE) && enable_i && is_high_op;

  always_comb begin
    state_d = state_q;
    case (state_q)
      MS_IDLE: begin
        if (start_high) begin
          state_d = MS_HIGH;
        end
      end
      MS_HIGH: begin
        // Wait here while the stage is stalled downstream
        if (ex_ready_i) begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper word captured on entry to the high state
  always_ff @(posedge clk) begin
    if (start_high) begin
      mulh_q <= product[2*XLEN-1:XLEN];
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign result_o     = (state_q == MS_HIGH) ? mulh_q : product[XLEN-1:0];
  assign ready_o      = ~start_high;
  assign multicycle_o = (state_q == MS_HIGH);

endmodule

// ==== ex_wb_ctrl.sv ====
// Forward-port select, EX/WB pipeline register, stage ready and valid
`timescale 1ns/1ps

module ex_wb_ctrl #(
  parameter int XLEN = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Unit enables
  input  logic                   alu_en_i,
  input  logic                   mult_en_i,
  input  logic                   csr_access_i,
  input  logic                   lsu_en_i,
  // Result sources
  input  logic [XLEN-1:0]        alu_result_i,
  input  logic [XLEN-1:0]        mult_result_i,
  input  logic [XLEN-1:0]        csr_rdata_i,
  // Status
  input  logic                   mult_ready_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,
  input  logic                   wb_ready_i,
  input  logic                   branch_in_ex_i,
  // Write requests from ID
  input  logic                   regfile_alu_we_i,
  input  ex_cfg_pkg::reg_addr_t  regfile_alu_waddr_i,
  input  logic                   regfile_we_i,
  input  ex_cfg_pkg::reg_addr_t  regfile_waddr_i,
  input  logic [XLEN-1:0]        lsu_rdata_i,
  // Forward port
  output logic                   regfile_alu_we_fw_o,
  output ex_cfg_pkg::reg_addr_t  regfile_alu_waddr_fw_o,
  output logic [XLEN-1:0]        regfile_alu_wdata_fw_o,
  // Writeback port
  output logic                   regfile_we_wb_o,
  output ex_cfg_pkg::reg_addr_t  regfile_waddr_wb_o,
  output logic [XLEN-1:0]        regfile_wdata_wb_o,
  // Stage handshake levels
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic                   wb_we_q;
  ex_cfg_pkg::reg_addr_t  wb_waddr_q;
  logic                   units_ready;

  // Forward port, later assignments win
  // CSR over multiplier over ALU, zero when idle
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
    if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Stage status
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  // Branches resolve in EX, so they never wait on writeback
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // EX/WB register for the LSU write port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else if (ex_valid_o) begin
      // A faulting load drops its write
      wb_we_q <= regfile_we_i & ~lsu_err_i;
      if (regfile_we_i && !lsu_err_i) begin
        wb_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      wb_we_q <= 1'b0; // flush, nothing new came in
    end
  end

  assign regfile_we_wb_o    = wb_we_q;
  assign regfile_waddr_wb_o = wb_waddr_q;
  // Load data arrives in the WB cycle itself
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// ==== ex_stage.sv ====
// Execute stage top: ALU, multiplier and writeback control, branch outputs
`timescale 1ns/1ps

module ex_stage #(
  parameter int XLEN = ex_cfg_pkg::XLEN_DEF
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // ALU operation from ID
  input  ex_op_pkg::alu_op_e     alu_operator_i,
  input  logic [XLEN-1:0]        alu_operand_a_i,
  input  logic [XLEN-1:0]        alu_operand_b_i,
  input  logic [XLEN-1:0]        alu_operand_c_i,
  input  logic                   alu_en_i,

  // Multiplier operation from ID
  input  ex_op_pkg::mul_op_e     mult_operator_i,
  input  logic [XLEN-1:0]        mult_operand_a_i,
  input  logic [XLEN-1:0]        mult_operand_b_i,
  input  logic                   mult_en_i,
  output logic                   mult_multicycle_o,

  // CSR read
  input  logic                   csr_access_i,
  input  logic [XLEN-1:0]        csr_rdata_i,

  // LSU status and load data
  input  logic                   lsu_en_i,
  input  logic [XLEN-1:0]        lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,

  // Control and write requests from ID
  input  logic                   branch_in_ex_i,
  input  logic                   regfile_alu_we_i,
  input  ex_cfg_pkg::reg_addr_t  regfile_alu_waddr_i,
  input  logic                   regfile_we_i,
  input  ex_cfg_pkg::reg_addr_t  regfile_waddr_i,
  input  logic                   wb_ready_i,

  // Forward port to ID and register file
  output logic                   regfile_alu_we_fw_o,
  output ex_cfg_pkg::reg_addr_t  regfile_alu_waddr_fw_o,
  output logic [XLEN-1:0]        regfile_alu_wdata_fw_o,

  // Writeback port
  output logic                   regfile_we_wb_o,
  output ex_cfg_pkg::reg_addr_t  regfile_waddr_wb_o,
  output logic [XLEN-1:0]        regfile_wdata_wb_o,

  // Branch resolution to IF
  output logic [XLEN-1:0]        jump_target_o,
  output logic                   branch_decision_o,

  // Stall control
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  ex_alu #(
    .XLEN (XLEN)
  ) i_alu (
    .enable_i     (alu_en_i),
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Branch target is precomputed in ID and passed as operand C
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  // Sequencer leaves its high state once the stage moves on
  ex_mult #(
    .XLEN (XLEN)
  ) i_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////////////////////////
  // Writeback control
  ////////////////////////////////////////////////////////////

  ex_wb_ctrl #(
    .XLEN (XLEN)
  ) i_wb_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// ==== ex_stage_chk.sv ====
// Concurrent assertions on reset state, stage valid and multiplier sequencing
`timescale 1ns/1ps

module ex_stage_chk (
  input logic                clk,
  input logic                rst_n,
  input logic                mult_en_i,
  input ex_op_pkg::mul_op_e  mult_operator_i,
  input logic                mult_ready,
  input logic                mult_multicycle_o,
  input logic                ex_ready_o,
  input logic                ex_valid_o,
  input logic                wb_ready_i,
  input logic                regfile_we_wb_o
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // Writeback port starts empty
  wb_clear_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !regfile_we_wb_o)
    else begin
      $error("Writeback write enable set right after reset");
      fail_count++;
    end

  // No valid result while writeback stalls
  valid_needs_wb_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> wb_ready_i)
    else begin
      $error("Stage valid while writeback not ready");
      fail_count++;
    end

  // High word follows a started request, or waits there for the stage
  multicycle_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o |->
      $past(mult_en_i && (mult_operator_i != ex_op_pkg::MUL_L) && !mult_ready) ||
      $past(mult_multicycle_o && !ex_ready_o))
    else begin
      $error("Multicycle flag without a pending high-word request");
      fail_count++;
    end

endmodule

bind ex_stage ex_stage_chk i_chk (
  .clk               (clk),
  .rst_n             (rst_n),
  .mult_en_i         (mult_en_i),
  .mult_operator_i   (mult_operator_i),
  .mult_ready        (mult_ready),
  .mult_multicycle_o (mult_multicycle_o),
  .ex_ready_o        (ex_ready_o),
  .ex_valid_o        (ex_valid_o),
  .wb_ready_i        (wb_ready_i),
  .regfile_we_wb_o   (regfile_we_wb_o)
);

// ==== tb_ex_stage.sv ====
// Execute stage testbench with stimulus, reference model, compare tasks and timeout
`timescale 1ns/1ps

module tb_ex_stage;

  localparam int XLEN       = ex_cfg_pkg::XLEN_DEF;
  localparam int SHW        = $clog2(XLEN);
  localparam int NUM_OPS    = 8;
  // Three cycles per operation over all tests plus a margin for reset
  localparam int MAX_CYCLES = NUM_OPS * (16 + 6 + 4) * 3 + 100;

  logic                   clk;
  logic                   rst_n;
  integer                 seed;
  int                     cycle_count = 0;

  ex_op_pkg::alu_op_e     alu_operator_i;
  logic [XLEN-1:0]        alu_operand_a_i;
  logic [XLEN-1:0]        alu_operand_b_i;
  logic [XLEN-1:0]        alu_operand_c_i;
  logic                   alu_en_i;
  ex_op_pkg::mul_op_e     mult_operator_i;
  logic [XLEN-1:0]        mult_operand_a_i;
  logic [XLEN-1:0]        mult_operand_b_i;
  logic                   mult_en_i;
  logic                   mult_multicycle_o;
  logic                   csr_access_i;
  logic [XLEN-1:0]        csr_rdata_i;
  logic                   lsu_en_i;
  logic [XLEN-1:0]        lsu_rdata_i;
  logic                   lsu_ready_ex_i;
  logic                   lsu_err_i;
  logic                   branch_in_ex_i;
  logic                   regfile_alu_we_i;
  ex_cfg_pkg::reg_addr_t  regfile_alu_waddr_i;
  logic                   regfile_we_i;
  ex_cfg_pkg::reg_addr_t  regfile_waddr_i;
  logic                   wb_ready_i;
  logic                   regfile_alu_we_fw_o;
  ex_cfg_pkg::reg_addr_t  regfile_alu_waddr_fw_o;
  logic [XLEN-1:0]        regfile_alu_wdata_fw_o;
  logic                   regfile_we_wb_o;
  ex_cfg_pkg::reg_addr_t  regfile_waddr_wb_o;
  logic [XLEN-1:0]        regfile_wdata_wb_o;
  logic [XLEN-1:0]        jump_target_o;
  logic                   branch_decision_o;
  logic                   ex_ready_o;
  logic                   ex_valid_o;

  // Expected values and the groups armed for the coming rising edge
  logic                   chk_fw;
  logic                   chk_br;
  logic                   chk_rv;
  logic                   chk_mc;
  logic                   chk_wb;
  logic                   exp_fw_we;
  ex_cfg_pkg::reg_addr_t  exp_fw_waddr;
  logic [XLEN-1:0]        exp_fw_data;
  logic                   exp_br;
  logic [XLEN-1:0]        exp_jump;
  logic                   exp_ready;
  logic                   exp_valid;
  logic                   exp_mc;
  logic                   exp_wb_we;
  ex_cfg_pkg::reg_addr_t  exp_wb_waddr;
  logic [XLEN-1:0]        exp_wb_data;

  ex_stage #(
    .XLEN (XLEN)
  ) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Returns {compare bit, result word}
  function automatic logic [XLEN:0] ref_model(input logic is_mul,
      input ex_op_pkg::alu_op_e aop, input ex_op_pkg::mul_op_e mop,
      input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ea;
    logic [2*XLEN-1:0] eb;
    logic [2*XLEN-1:0] prod;
    logic [XLEN-1:0]   res;
    logic [SHW-1:0]    sh;
    logic              lt_s;
    logic              lt_u;
    logic              c;
    sh   = b[SHW-1:0];
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    c    = 1'b0;
    res  = '0;
    if (is_mul) begin
      // A is signed for MULH and MULHSU and B only for MULH
      ea   = {{XLEN{a[XLEN-1] & (mop == ex_op_pkg::MUL_H || mop == ex_op_pkg::MUL_HSU)}}, a};
      eb   = {{XLEN{b[XLEN-1] & (mop == ex_op_pkg::MUL_H)}}, b};
      prod = ea * eb;
      res  = (mop == ex_op_pkg::MUL_L) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    end else begin
      case (aop)
        ex_op_pkg::ALU_ADD:  res = a + b;
        ex_op_pkg::ALU_SUB:  res = a - b;
        ex_op_pkg::ALU_AND:  res = a & b;
        ex_op_pkg::ALU_OR:   res = a | b;
        ex_op_pkg::ALU_XOR:  res = a ^ b;
        ex_op_pkg::ALU_SLL:  res = a << sh;
        ex_op_pkg::ALU_SRL:  res = a >> sh;
        // Arithmetic shift fills the vacated top bits with the sign
        ex_op_pkg::ALU_SRA:  res = (a >> sh) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> sh));
        ex_op_pkg::ALU_EQ:   c = (a == b);
        ex_op_pkg::ALU_NE:   c = (a != b);
        ex_op_pkg::ALU_SLT,
        ex_op_pkg::ALU_LT:   c = lt_s;
        ex_op_pkg::ALU_GE:   c = !lt_s;
        ex_op_pkg::ALU_GEU:  c = !lt_u;
        default:             c = lt_u;
      endcase
      // Compare group writes its flag as a word
      if (aop >= ex_op_pkg::ALU_SLT) begin
        res[0] = c;
      end
    end
    return {c, res};
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
      input logic [XLEN-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input ex_cfg_pkg::reg_addr_t exp,
      input ex_cfg_pkg::reg_addr_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Sampled at the rising edge before any register updates
  always @(posedge clk) begin
    if (rst_n) begin
      if (chk_fw) begin
        check_bit("regfile_alu_we_fw_o", exp_fw_we, regfile_alu_we_fw_o);
        check_addr("regfile_alu_waddr_fw_o", exp_fw_waddr, regfile_alu_waddr_fw_o);
        check_word("regfile_alu_wdata_fw_o", exp_fw_data, regfile_alu_wdata_fw_o);
      end
      if (chk_br) begin
        check_bit("branch_decision_o", exp_br, branch_decision_o);
        check_word("jump_target_o", exp_jump, jump_target_o);
      end
      if (chk_rv) begin
        check_bit("ex_ready_o", exp_ready, ex_ready_o);
        check_bit("ex_valid_o", exp_valid, ex_valid_o);
      end
      if (chk_mc) begin
        check_bit("mult_multicycle_o", exp_mc, mult_multicycle_o);
      end
      if (chk_wb) begin
        check_bit("regfile_we_wb_o", exp_wb_we, regfile_we_wb_o);
        check_addr("regfile_waddr_wb_o", exp_wb_waddr, regfile_waddr_wb_o);
        check_word("regfile_wdata_wb_o", exp_wb_data, regfile_wdata_wb_o);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      stop_on_error($sformatf("Timeout, tests still running after %0d cycles", MAX_CYCLES));
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic draw_word(output logic [XLEN-1:0] w);
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    w = r[XLEN-1:0];
  endtask

  task automatic draw_addr(output ex_cfg_pkg::reg_addr_t ad);
    logic [31:0] r;
    r  = $random(seed);
    ad = r[ex_cfg_pkg::REG_ADDR_W-1:0];
  endtask

  task automatic clear_checks();
    chk_fw = 1'b0;
    chk_br = 1'b0;
    chk_rv = 1'b0;
    chk_mc = 1'b0;
    chk_wb = 1'b0;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    clear_checks();
  endtask

  // All units off with the stage free to advance
  task automatic go_idle();
    alu_operator_i      = ex_op_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = ex_op_pkg::MUL_L;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  // Forward port follows the request inputs of this cycle
  task automatic set_fw(input logic [XLEN-1:0] data);
    exp_fw_we    = regfile_alu_we_i;
    exp_fw_waddr = regfile_alu_waddr_i;
    exp_fw_data  = data;
    chk_fw       = 1'b1;
  endtask

  task automatic set_rv(input logic ready, input logic valid);
    exp_ready = ready;
    exp_valid = valid;
    chk_rv    = 1'b1;
  endtask

  // Fresh load data that passes straight through to WB
  task automatic set_wb(input logic we, input ex_cfg_pkg::reg_addr_t addr);
    draw_word(lsu_rdata_i);
    exp_wb_we    = we;
    exp_wb_waddr = addr;
    exp_wb_data  = lsu_rdata_i;
    chk_wb       = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic run_alu_ops();
    logic [XLEN:0] exp;
    for (int r = 0; r < NUM_OPS; r++) begin
      for (int op = 0; op < 16; op++) begin
        next_cycle();
        go_idle();
        alu_operator_i = ex_op_pkg::alu_op_e'(op);
        draw_word(alu_operand_a_i);
        draw_word(alu_operand_b_i);
        // Equal operands now and then for the EQ and GE outcomes
        if (r % 4 == 0) begin
          alu_operand_b_i = alu_operand_a_i;
        end
        draw_addr(regfile_alu_waddr_i);
        alu_en_i         = 1'b1;
        regfile_alu_we_i = 1'b1;
        exp = ref_model(1'b0, alu_operator_i, ex_op_pkg::MUL_L,
                        alu_operand_a_i, alu_operand_b_i);
        set_fw(exp[XLEN-1:0]);
        set_rv(1'b1, 1'b1);
      end
    end
  endtask

  task automatic run_branches();
    logic [XLEN:0] exp;
    for (int r = 0; r < NUM_OPS; r++) begin
      for (int op = int'(ex_op_pkg::ALU_EQ); op <= int'(ex_op_pkg::ALU_GEU); op++) begin
        next_cycle();
        go_idle();
        alu_operator_i = ex_op_pkg::alu_op_e'(op);
        draw_word(alu_operand_a_i);
        draw_word(alu_operand_b_i);
        draw_word(alu_operand_c_i);
        if (r % 2 == 0) begin
          alu_operand_b_i = alu_operand_a_i;
        end
        alu_en_i       = 1'b1;
        branch_in_ex_i = 1'b1;
        // A branch leaves EX even with writeback stalled
        wb_ready_i     = 1'b0;
        exp      = ref_model(1'b0, alu_operator_i, ex_op_pkg::MUL_L,
                             alu_operand_a_i, alu_operand_b_i);
        exp_br   = exp[XLEN];
        exp_jump = alu_operand_c_i;
        chk_br   = 1'b1;
        set_rv(1'b1, 1'b0);
      end
    end
    // Equal operands but the ALU is off, so no branch is taken
    next_cycle();
    go_idle();
    alu_operator_i = ex_op_pkg::ALU_EQ;
    draw_word(alu_operand_a_i);
    alu_operand_b_i = alu_operand_a_i;
    draw_word(alu_operand_c_i);
    exp_br   = 1'b0;
    exp_jump = alu_operand_c_i;
    chk_br   = 1'b1;
  endtask

  task automatic run_mults();
    logic [XLEN:0] exp;
    for (int r = 0; r < NUM_OPS; r++) begin
      for (int op = 0; op < 4; op++) begin
        next_cycle();
        go_idle();
        mult_operator_i = ex_op_pkg::mul_op_e'(op);
        draw_word(mult_operand_a_i);
        draw_word(mult_operand_b_i);
        draw_addr(regfile_alu_waddr_i);
        mult_en_i        = 1'b1;
        regfile_alu_we_i = 1'b1;
        exp    = ref_model(1'b1, ex_op_pkg::ALU_ADD, mult_operator_i,
                           mult_operand_a_i, mult_operand_b_i);
        exp_mc = 1'b0;
        chk_mc = 1'b1;
        if (mult_operator_i == ex_op_pkg::MUL_L) begin
          set_fw(exp[XLEN-1:0]);
          set_rv(1'b1, 1'b1);
        end else begin
          set_rv(1'b0, 1'b0);
          // High word shows one cycle later with the inputs held
          next_cycle();
          set_fw(exp[XLEN-1:0]);
          set_rv(1'b1, 1'b1);
          exp_mc = 1'b1;
          chk_mc = 1'b1;
        end
      end
    end
  endtask

  task automatic run_priority();
    logic [XLEN:0] exp;
    // CSR over ALU
    next_cycle();
    go_idle();
    draw_word(alu_operand_a_i);
    draw_word(csr_rdata_i);
    draw_addr(regfile_alu_waddr_i);
    alu_en_i         = 1'b1;
    csr_access_i     = 1'b1;
    regfile_alu_we_i = 1'b1;
    set_fw(csr_rdata_i);
    set_rv(1'b1, 1'b1);
    // CSR over multiplier and ALU
    next_cycle();
    go_idle();
    draw_word(mult_operand_a_i);
    draw_word(mult_operand_b_i);
    draw_word(csr_rdata_i);
    alu_en_i     = 1'b1;
    mult_en_i    = 1'b1;
    csr_access_i = 1'b1;
    set_fw(csr_rdata_i);
    // Multiplier over ALU
    next_cycle();
    go_idle();
    draw_word(alu_operand_a_i);
    draw_word(mult_operand_a_i);
    draw_word(mult_operand_b_i);
    alu_en_i  = 1'b1;
    mult_en_i = 1'b1;
    exp = ref_model(1'b1, ex_op_pkg::ALU_ADD, ex_op_pkg::MUL_L,
                    mult_operand_a_i, mult_operand_b_i);
    set_fw(exp[XLEN-1:0]);
    // Nothing enabled
    next_cycle();
    go_idle();
    draw_word(alu_operand_a_i);
    draw_word(csr_rdata_i);
    set_fw('0);
    set_rv(1'b1, 1'b0);
  endtask

  task automatic run_wb_reg();
    ex_cfg_pkg::reg_addr_t a1;
    ex_cfg_pkg::reg_addr_t a3;
    next_cycle();
    go_idle();
    lsu_en_i     = 1'b1;
    regfile_we_i = 1'b1;
    draw_addr(regfile_waddr_i);
    a1 = regfile_waddr_i;
    set_rv(1'b1, 1'b1);
    next_cycle();
    go_idle();
    set_wb(1'b1, a1);
    // The idle cycle before has flushed the write
    next_cycle();
    go_idle();
    set_wb(1'b0, a1);
    // Faulting load drops both the write and its address
    next_cycle();
    go_idle();
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    lsu_err_i       = 1'b1;
    regfile_waddr_i = a1 ^ '1;
    set_rv(1'b1, 1'b1);
    next_cycle();
    go_idle();
    set_wb(1'b0, a1);
    // Capture and then hold under a WB stall
    next_cycle();
    go_idle();
    lsu_en_i     = 1'b1;
    regfile_we_i = 1'b1;
    draw_addr(regfile_waddr_i);
    a3 = regfile_waddr_i;
    repeat (2) begin
      next_cycle();
      go_idle();
      lsu_en_i        = 1'b1;
      regfile_we_i    = 1'b1;
      regfile_waddr_i = a3 ^ '1;
      wb_ready_i      = 1'b0;
      set_wb(1'b1, a3);
      set_rv(1'b0, 1'b0);
    end
    next_cycle();
    go_idle();
    set_wb(1'b1, a3);
    next_cycle();
    go_idle();
    set_wb(1'b0, a3);
  endtask

  initial begin
    seed  = 32'h47cb;
    rst_n = 1'b0;
    go_idle();
    clear_checks();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    run_alu_ops();
    run_branches();
    run_mults();
    run_priority();
    run_wb_reg();
    next_cycle();
    go_idle();
    @(negedge clk);
    if (i_dut.i_chk.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== src.f ====
ex_cfg_pkg.sv
ex_op_pkg.sv
ex_alu.sv
ex_mult.sv
ex_wb_ctrl.sv
ex_stage.sv
ex_stage_chk.sv
tb_ex_stage.sv
